// ==== flist.f ====
+incdir+src
+incdir+testbench
src/decoder_pkg.sv
src/decoder_regs.sv
src/biphase_to_nrz.sv
src/mrk_spc_decode.sv
src/derandomizer.sv
src/format_output.sv
src/decoder.sv
testbench/decoder_tb.sv

// ==== Makefile ====
# Verilator build and run for the bit decoder testbench

TOP       ?= decoder_tb
FLIST     ?= flist.f
VERILATOR ?= verilator
SEED_ARGS ?= +verilator+seed+1

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check for the pass message"
	@echo "  clean  remove obj_dir"
	@echo "  help   list the targets"

test:
	$(VERILATOR) --binary -f $(FLIST) --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP) $(SEED_ARGS)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir

// ==== testbench/decoder_model.svh ====
// Reference model for the bit decoder testbench
// Builds the expected output stream from the source symbols
// and the active control fields

`ifndef DECODER_MODEL_SVH
`define DECODER_MODEL_SVH

// Source symbols of the current run (half-symbols in biphase mode)
soft_sym_t   src_i[$];
soft_sym_t   src_q[$];
// Unscrambled bits used only by the derandomizer runs
bit          orig_bits[$];
// Expected words with one per compared output strobe
soft_sym_t   exp_i[$];
soft_sym_t   exp_q[$];
// Scrambler history with the newest bit at index 0
logic [14:0] scr_hist;

// Differential decode of one rail
function automatic soft_sym_t mark_space(dec_mode_e m, soft_sym_t cur, soft_sym_t prev);
  logic s;
  case (m)
    NRZ_M:   s = cur[SOFT_MSB] ^ prev[SOFT_MSB];
    NRZ_S:   s = ~(cur[SOFT_MSB] ^ prev[SOFT_MSB]);
    default: s = cur[SOFT_MSB];
  endcase
  return {s, cur[SOFT_MSB-1:0]};
endfunction

// Manchester pair gives the first half bit and the best confidence
function automatic soft_sym_t pair_halves(soft_sym_t h0, soft_sym_t h1);
  soft_conf_t c0;
  soft_conf_t c1;
  c0 = h0[SOFT_MSB-1:0];
  // Second half carries the inverted symbol
  c1 = ~h1[SOFT_MSB-1:0];
  return {h0[SOFT_MSB], (c1 > c0) ? c1 : c0};
endfunction

// Inversion then offset binary to sign-magnitude
function automatic soft_sym_t format_sym(soft_sym_t s, bit inv, bit sm);
  soft_sym_t v;
  v = inv ? ~s : s;
  if (sm && !v[SOFT_MSB]) begin
    v[SOFT_MSB-1:0] = ~v[SOFT_MSB-1:0];
  end
  return v;
endfunction

// Transmit side x^15 + x^14 + 1 scrambler
function bit scramble(bit b);
  bit s;
  s = b ^ scr_hist[14] ^ scr_hist[13];
  scr_hist = {scr_hist[13:0], s};
  return s;
endfunction

`endif

// ==== testbench/decoder_tb.sv ====
// Bit decoder testbench
// APB register checks followed by random symbol streams through
// each decode mode, compared against the reference model

`default_nettype none

`include "decoder_config.svh"

module decoder_tb
  import decoder_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_CYCLES = 6 * 300 * 8 + 4000;

  logic                   clk, rs, psel, penable, pwrite, sym_en, sym2x;
  logic [`DEC_APB_AW-1:0] paddr;
  logic [`DEC_APB_DW-1:0] pwdata;
  wire  [`DEC_APB_DW-1:0] prdata;
  wire                    pready, pslverr, cout, clk_inv;
  soft_sym_t              sym_i, sym_q;
  soft_sym_t              dout_i, dout_q;

  // Active control fields
  dec_mode_e cfg_mode;
  bit        cfg_sm, cfg_bip, cfg_swap, cfg_demux, cfg_der, cfg_inv, cfg_cinv;

  int          checks, errors, cycles, out_cnt, skip_n, test_no;
  bit          check_on;
  logic [31:0] lcg_state;

  `include "decoder_model.svh"

  decoder uut (
    .clk(clk), .rs(rs), .paddr_i(paddr), .psel_i(psel), .penable_i(penable),
    .pwrite_i(pwrite), .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready),
    .pslverr_o(pslverr), .sym_en_i(sym_en), .sym2x_en_i(sym2x), .sym_i_i(sym_i),
    .sym_q_i(sym_q), .dout_i_o(dout_i), .dout_q_o(dout_q), .cout_o(cout),
    .clk_inv_o(clk_inv)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run exceeded %0d cycles", MAX_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  function logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Advance n edges and settle past the last one
  task automatic step(int n);
    repeat (n) @(posedge clk);
    #10;
  endtask

  // ----------------------------------------
  // APB access
  // ----------------------------------------

  task automatic apb_write(logic [`DEC_APB_AW-1:0] addr, logic [15:0] data);
    @(posedge clk);
    #10;
    psel = 1'b1;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    step(1);
    penable = 1'b1;
    step(1);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_read(logic [`DEC_APB_AW-1:0] addr, output logic [15:0] data,
                          output logic err);
    @(posedge clk);
    #10;
    psel = 1'b1;
    paddr = addr;
    step(1);
    penable = 1'b1;
    // Mid access phase
    @(negedge clk);
    data = prdata;
    err = pslverr;
    check_value("pready_o", pready, 1);
    step(1);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic set_config();
    apb_write(`DEC_ADDR_CTRL, {7'd0, cfg_cinv, cfg_inv, cfg_der, cfg_demux, cfg_swap,
                               cfg_bip, cfg_sm, cfg_mode});
  endtask

  // ----------------------------------------
  // Expected stream and symbol driver
  // ----------------------------------------

  task automatic build_expected(output int first);
    soft_sym_t nrz_i[$];
    soft_sym_t nrz_q[$];
    soft_sym_t dec_i[$];
    soft_sym_t dec_q[$];
    soft_sym_t v;
    int        m;
    exp_i.delete();
    exp_q.delete();
    if (cfg_bip) begin
      for (int p = 0; p < src_i.size() / 2; p++) begin
        nrz_i.push_back(pair_halves(src_i[2*p], src_i[2*p+1]));
        nrz_q.push_back(src_q[2*p+1]);
      end
    end else begin
      nrz_i = src_i;
      nrz_q = src_q;
    end
    m = nrz_i.size();
    for (int j = 0; j < m; j++) begin
      dec_i.push_back(mark_space(cfg_mode, nrz_i[j], nrz_i[(j == 0) ? 0 : j-1]));
      dec_q.push_back(mark_space(cfg_mode, nrz_q[j], nrz_q[(j == 0) ? 0 : j-1]));
      // Descrambled sign is the original bit
      if (cfg_der) begin
        v = dec_i[j];
        v[SOFT_MSB] = orig_bits[j];
        dec_i[j] = v;
      end
    end
    if (cfg_demux) begin
      // Output t carries symbol t/2-2 with Q first unless swapped
      first = 6;
      for (int t = first; t < 2 * m; t++) begin
        v = (((t % 2) == 0) ^ cfg_swap) ? dec_q[t/2-2] : dec_i[t/2-2];
        exp_i.push_back(format_sym(v, cfg_inv, cfg_sm));
        exp_q.push_back(format_sym(dec_q[t/2-2], cfg_inv, cfg_sm));
      end
    end else begin
      // Three strobes of fill plus fifteen more for the descrambler
      first = cfg_der ? 18 : 4;
      for (int t = first; t < m; t++) begin
        exp_i.push_back(format_sym(dec_i[t-3], cfg_inv, cfg_sm));
        exp_q.push_back(format_sym(dec_q[t-3], cfg_inv, cfg_sm));
      end
    end
  endtask

  task automatic run_stream();
    int n;
    int first;
    n = src_i.size();
    build_expected(first);
    skip_n = first;
    out_cnt = 0;
    check_on = 1'b1;
    step(1);
    for (int k = 0; k < n; k++) begin
      sym_en = 1'b1;
      sym2x = 1'b1;
      sym_i = src_i[k];
      sym_q = src_q[k];
      step(1);
      sym_en = 1'b0;
      sym2x = 1'b0;
      step(3);
      sym2x = 1'b1;
      step(1);
      sym2x = 1'b0;
      step(3);
    end
    step(4);
    check_on = 1'b0;
    if (exp_i.size() != 0) begin
      errors++;
      $display("Output strobe missing: %0d expected words never appeared", exp_i.size());
    end
    src_i.delete();
    src_q.delete();
    orig_bits.delete();
  endtask

  // Compare on each output strobe away from the clock edge
  always @(negedge clk) begin
    if (check_on && cout) begin
      if (out_cnt >= skip_n) begin
        if (exp_i.size() == 0) begin
          errors++;
          $display("Extra output strobe at %0t with no expected word", $time);
        end else begin
          check_value("dout_i_o", dout_i, exp_i.pop_front());
          check_value("dout_q_o", dout_q, exp_q.pop_front());
        end
      end
      out_cnt++;
    end
  end

  task automatic add_random(int n);
    logic [31:0] r;
    for (int k = 0; k < n; k++) begin
      r = lcg_next();
      src_i.push_back(r[31:29]);
      src_q.push_back(r[27:25]);
    end
  endtask

  task automatic report_test(string name, int c0, int e0);
    test_no++;
    $display("Test %0d %s: %0d checks, %0d errors", test_no, name, checks - c0,
             errors - e0);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial begin
    logic [15:0] rd;
    logic [15:0] val;
    logic        err;
    logic [31:0] r;
    int          c0;
    int          e0;
    rs = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    sym_en = 1'b0;
    sym2x = 1'b0;
    sym_i = '0;
    sym_q = '0;
    lcg_state = 32'h5d3aaa78;
    scr_hist = '0;
    {checks, errors, cycles, out_cnt, skip_n, test_no} = '0;
    check_on = 1'b0;
    {cfg_sm, cfg_bip, cfg_swap, cfg_demux, cfg_der, cfg_inv, cfg_cinv} = '0;
    cfg_mode = NRZ_L;
    step(10);
    rs = 1'b0;

    // Register access and reset state
    c0 = checks;
    e0 = errors;
    apb_read(`DEC_ADDR_CTRL, rd, err);
    check_value("prdata_o", rd, 0);
    check_value("cout_o", cout, 0);
    for (int k = 0; k < 20; k++) begin
      val = lcg_next() >> 16;
      apb_write(`DEC_ADDR_CTRL, val);
      apb_read(`DEC_ADDR_CTRL, rd, err);
      check_value("prdata_o", rd, val & 16'h01ff);
      check_value("pslverr_o", err, 0);
    end
    apb_read(12'h004, rd, err);
    check_value("prdata_o", rd, 0);
    check_value("pslverr_o", err, 1);
    set_config();
    report_test("APB register", c0, e0);

    // Level, mark and space in both output formats
    c0 = checks;
    e0 = errors;
    for (int m = 0; m < 3; m++) begin
      for (int s = 0; s < 2; s++) begin
        cfg_mode = dec_mode_e'(m);
        cfg_sm = s[0];
        set_config();
        add_random(50);
        run_stream();
      end
    end
    report_test("NRZ-L/M/S decode", c0, e0);

    // Manchester halves paired into NRZ
    c0 = checks;
    e0 = errors;
    cfg_bip = 1'b1;
    for (int m = 0; m < 2; m++) begin
      cfg_mode = dec_mode_e'(m);
      cfg_sm = m[0];
      set_config();
      add_random(150);
      run_stream();
    end
    cfg_bip = 1'b0;
    report_test("biphase", c0, e0);

    // Q and I interleaved at twice the rate
    c0 = checks;
    e0 = errors;
    cfg_demux = 1'b1;
    cfg_mode = NRZ_M;
    for (int s = 0; s < 2; s++) begin
      cfg_swap = s[0];
      cfg_sm = s[0];
      set_config();
      add_random(150);
      run_stream();
    end
    {cfg_demux, cfg_swap, cfg_sm} = '0;
    report_test("demux", c0, e0);

    // Scrambled sign stream comes back as the original bits
    c0 = checks;
    e0 = errors;
    cfg_der = 1'b1;
    cfg_mode = NRZ_L;
    for (int s = 0; s < 2; s++) begin
      cfg_inv = s[0];
      set_config();
      scr_hist = '0;
      for (int k = 0; k < 150; k++) begin
        r = lcg_next();
        orig_bits.push_back(r[31]);
        src_i.push_back({scramble(r[31]), r[29:28]});
        src_q.push_back(r[27:25]);
      end
      run_stream();
    end
    {cfg_der, cfg_inv} = '0;
    report_test("derandomizer", c0, e0);

    // Clock inversion bit follows the register
    c0 = checks;
    e0 = errors;
    cfg_cinv = 1'b1;
    cfg_mode = NRZ_S;
    set_config();
    check_value("clk_inv_o", clk_inv, 1);
    add_random(50);
    run_stream();
    cfg_cinv = 1'b0;
    set_config();
    step(1);
    check_value("clk_inv_o", clk_inv, 0);
    report_test("clock invert", c0, e0);

    $display("Total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/decoder.sv ====
// Telemetry bit decoder top level
// Biphase to NRZ, mark/space decode, QPSK demux, derandomizer
// and output formatting on soft I and Q symbols, with the
// control register on APB

`default_nettype none

`include "decoder_config.svh"

module decoder
  import decoder_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   rs,
  input  wire logic [`DEC_APB_AW-1:0] paddr_i,
  input  wire logic                   psel_i,
  input  wire logic                   penable_i,
  input  wire logic                   pwrite_i,
  input  wire logic [`DEC_APB_DW-1:0] pwdata_i,
  output logic      [`DEC_APB_DW-1:0] prdata_o,
  output logic                        pready_o,
  output logic                        pslverr_o,
  input  wire logic                   sym_en_i,
  input  wire logic                   sym2x_en_i,
  input  wire soft_sym_t              sym_i_i,
  input  wire soft_sym_t              sym_q_i,
  output soft_sym_t                   dout_i_o,
  output soft_sym_t                   dout_q_o,
  output logic                        cout_o,
  output logic                        clk_inv_o
);

  dec_mode_e mode;
  logic      sign_mag, biphase, swap, demux, derandomize, data_inv;

  decoder_regs u_regs (
    .clk          (clk),
    .rs           (rs),
    .paddr_i      (paddr_i),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .pwdata_i     (pwdata_i),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o),
    .mode_o       (mode),
    .sign_mag_o   (sign_mag),
    .biphase_o    (biphase),
    .swap_o       (swap),
    .demux_o      (demux),
    .derandomize_o(derandomize),
    .data_inv_o   (data_inv),
    .clk_inv_o    (clk_inv_o)
  );

  // ----------------------------------------
  // NRZ and previous symbols (stage 1)
  // ----------------------------------------

  soft_sym_t nrz_i, nrz_i_q, nrz_q_q, prev_i_q, prev_q_q;
  logic      data_en;

  // Pair strobe in biphase mode, symbol strobe otherwise
  biphase_to_nrz u_biphase (
    .clk      (clk),
    .rs       (rs),
    .sym_en_i (sym_en_i),
    .biphase_i(biphase),
    .sym_i    (sym_i_i),
    .nrz_o    (nrz_i),
    .pair_en_o(data_en)
  );

  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      nrz_i_q  <= '0;
      nrz_q_q  <= '0;
      prev_i_q <= '0;
      prev_q_q <= '0;
    end else if (data_en) begin
      nrz_i_q  <= nrz_i;
      nrz_q_q  <= sym_q_i;
      // One symbol behind for the differential modes
      prev_i_q <= nrz_i_q;
      prev_q_q <= nrz_q_q;
    end
  end

  // ----------------------------------------
  // Mark/space decode per rail (stage 2)
  // ----------------------------------------

  soft_sym_t dec_i, dec_q;

  mrk_spc_decode u_mrk_spc_i (
    .clk       (clk),
    .rs        (rs),
    .en_i      (data_en),
    .mode_i    (mode),
    .din_i     (nrz_i_q),
    .last_din_i(prev_i_q),
    .dout_o    (dec_i)
  );

  mrk_spc_decode u_mrk_spc_q (
    .clk       (clk),
    .rs        (rs),
    .en_i      (data_en),
    .mode_i    (mode),
    .din_i     (nrz_q_q),
    .last_din_i(prev_q_q),
    .dout_o    (dec_q)
  );

  // ----------------------------------------
  // Demux select (stage 3)
  // ----------------------------------------

  logic      stage_en, sym_start_q, take_q;
  soft_sym_t sel_i, sel_i_q, sel_q_q;

  // Twice rate while demuxing
  assign stage_en = demux ? sym2x_en_i : data_en;

  // Low on the 2x tick that starts a symbol
  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      sym_start_q <= 1'b0;
    end else if (sym2x_en_i) begin
      sym_start_q <= sym_en_i;
    end
  end

  // Q first and I second unless swapped
  assign take_q = sym_start_q ^ swap;
  assign sel_i  = (demux && take_q) ? dec_q : dec_i;

  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      sel_i_q <= '0;
      sel_q_q <= '0;
    end else if (stage_en) begin
      sel_i_q <= sel_i;
      sel_q_q <= dec_q;
    end
  end

  // ----------------------------------------
  // Derandomize and format (stage 4)
  // ----------------------------------------

  logic      derand_bit;
  soft_sym_t fmt_in_i, fmt_in_q;

  // Runs alongside the select register so its bit lines up with sel_i_q
  derandomizer u_derand (
    .clk   (clk),
    .rs    (rs),
    .en_i  (stage_en),
    .din_i (sel_i[SOFT_MSB]),
    .dout_o(derand_bit)
  );

  always_comb begin
    fmt_in_i = sel_i_q;
    fmt_in_q = sel_q_q;
    if (derandomize) begin
      fmt_in_i[SOFT_MSB] = derand_bit;
    end
    // Q shares the derandomized sign in demux mode
    if (derandomize && demux) begin
      fmt_in_q[SOFT_MSB] = derand_bit;
    end
  end

  format_output u_format_i (
    .clk       (clk),
    .rs        (rs),
    .en_i      (stage_en),
    .data_inv_i(data_inv),
    .sign_mag_i(sign_mag),
    .din_i     (fmt_in_i),
    .dout_o    (dout_i_o)
  );

  format_output u_format_q (
    .clk       (clk),
    .rs        (rs),
    .en_i      (stage_en),
    .data_inv_i(data_inv),
    .sign_mag_i(sign_mag),
    .din_i     (fmt_in_q),
    .dout_o    (dout_q_o)
  );

  // ----------------------------------------
  // Output strobe
  // ----------------------------------------

  logic stage_en_q;

  // High in the cycle after the output registers load
  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      stage_en_q <= 1'b0;
    end else begin
      stage_en_q <= stage_en;
    end
  end

  assign cout_o = stage_en_q;

endmodule

`default_nettype wire

// ==== src/format_output.sv ====
// Output formatting for one rail
// Optional data inversion and offset binary to
// sign-magnitude conversion, then the output register

`default_nettype none

module format_output
  import decoder_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rs,
  input  wire logic      en_i,
  input  wire logic      data_inv_i,
  input  wire logic      sign_mag_i,
  input  wire soft_sym_t din_i,
  output soft_sym_t      dout_o
);

  soft_sym_t inv_sym;
  soft_sym_t fmt_sym;

  // Whole symbol flips, sign and confidence
  assign inv_sym = data_inv_i ? ~din_i : din_i;

  // Zeros count down in offset binary, flip them to magnitude
  always_comb begin
    fmt_sym = inv_sym;
    if (sign_mag_i && !inv_sym[SOFT_MSB]) begin
      fmt_sym[SOFT_MSB-1:0] = ~inv_sym[SOFT_MSB-1:0];
    end
  end

  // Stage 4 register
  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      dout_o <= '0;
    end else if (en_i) begin
      dout_o <= fmt_sym;
    end
  end

endmodule

`default_nettype wire

// ==== src/derandomizer.sv ====
// NRZ derandomizer
// Self-synchronizing descrambler for x^15 + x^14 + 1
// working on the received sign bit stream

`default_nettype none

module derandomizer (
  input  wire logic clk,
  input  wire logic rs,
  input  wire logic en_i,
  input  wire logic din_i,
  output logic      dout_o
);

  localparam int unsigned STAGES = 15;

  // Received bits, index 0 is the newest
  logic [STAGES-1:0] shift_q;

  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      shift_q <= '0;
      dout_o  <= 1'b0;
    end else if (en_i) begin
      // Scrambled bit goes in, feedback comes from received bits
      shift_q <= {shift_q[STAGES-2:0], din_i};
      // Taps 15 and 14 of the polynomial
      dout_o  <= din_i ^ shift_q[STAGES-1] ^ shift_q[STAGES-2];
    end
  end

endmodule

`default_nettype wire

// ==== src/mrk_spc_decode.sv ====
// Mark / space differential decoder
// Decodes NRZ-L, NRZ-M or NRZ-S on one rail, keeps the
// confidence bits as they are

`default_nettype none

module mrk_spc_decode
  import decoder_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rs,
  input  wire logic      en_i,
  input  wire dec_mode_e mode_i,
  input  wire soft_sym_t din_i,
  input  wire soft_sym_t last_din_i,
  output soft_sym_t      dout_o
);

  logic transition;
  logic sign_dec;

  // Hard decision changed since the previous symbol
  assign transition = din_i[SOFT_MSB] ^ last_din_i[SOFT_MSB];

  always_comb begin
    case (mode_i)
      NRZ_M:   sign_dec = transition;
      NRZ_S:   sign_dec = ~transition;
      // Level coding, also the unnamed value 3
      default: sign_dec = din_i[SOFT_MSB];
    endcase
  end

  // Stage 2 register
  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      dout_o <= '0;
    end else if (en_i) begin
      dout_o <= {sign_dec, din_i[SOFT_MSB-1:0]};
    end
  end

endmodule

`default_nettype wire

// ==== src/biphase_to_nrz.sv ====
// Biphase to NRZ conversion
// Pairs Manchester half-symbols on the I rail into NRZ
// symbols, passes symbols through outside biphase mode

`default_nettype none

module biphase_to_nrz
  import decoder_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rs,
  input  wire logic      sym_en_i,
  input  wire logic      biphase_i,
  input  wire soft_sym_t sym_i,
  output soft_sym_t      nrz_o,
  output logic           pair_en_o
);

  soft_sym_t  first_half;
  logic       second_phase;
  soft_conf_t conf_first;
  soft_conf_t conf_second;
  soft_conf_t conf_best;

  // Last half-symbol seen, first half when a pair completes
  always_ff @(posedge clk) begin
    if (sym_en_i) begin
      first_half <= sym_i;
    end
  end

  // Pairing phase, held at first half outside biphase mode
  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      second_phase <= 1'b0;
    end else if (!biphase_i) begin
      second_phase <= 1'b0;
    end else if (sym_en_i) begin
      second_phase <= ~second_phase;
    end
  end

  // Second half carries the inverted symbol
  assign conf_first  = first_half[SOFT_MSB-1:0];
  assign conf_second = ~sym_i[SOFT_MSB-1:0];
  assign conf_best   = (conf_second > conf_first) ? conf_second : conf_first;

  // Bit from the first half, best confidence of the pair
  assign nrz_o     = biphase_i ? {first_half[SOFT_MSB], conf_best} : sym_i;
  assign pair_en_o = biphase_i ? (sym_en_i & second_phase) : sym_en_i;

endmodule

`default_nettype wire

// ==== src/decoder_regs.sv ====
// Decoder control register
// APB slave with zero wait states, holds the control word
// and drives its fields into the decoder datapath

`default_nettype none

`include "decoder_config.svh"

module decoder_regs
  import decoder_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   rs,
  input  wire logic [`DEC_APB_AW-1:0] paddr_i,
  input  wire logic                   psel_i,
  input  wire logic                   penable_i,
  input  wire logic                   pwrite_i,
  input  wire logic [`DEC_APB_DW-1:0] pwdata_i,
  output logic      [`DEC_APB_DW-1:0] prdata_o,
  output logic                        pready_o,
  output logic                        pslverr_o,
  output dec_mode_e                   mode_o,
  output logic                        sign_mag_o,
  output logic                        biphase_o,
  output logic                        swap_o,
  output logic                        demux_o,
  output logic                        derandomize_o,
  output logic                        data_inv_o,
  output logic                        clk_inv_o
);

  // ----------------------------------------
  // Control word layout, bit 0 upward
  // ----------------------------------------

  localparam int unsigned CTRL_W      = 9;
  localparam int unsigned B_MODE      = 0;  // two bits
  localparam int unsigned B_SIGN_MAG  = 2;
  localparam int unsigned B_BIPHASE   = 3;
  localparam int unsigned B_SWAP      = 4;
  localparam int unsigned B_DEMUX     = 5;
  localparam int unsigned B_DERAND    = 6;
  localparam int unsigned B_DATA_INV  = 7;
  localparam int unsigned B_CLK_INV   = 8;

  logic [CTRL_W-1:0] ctrl_q;
  logic              ctrl_hit;
  logic              access;

  // Only one mapped register
  assign ctrl_hit = (paddr_i == `DEC_ADDR_CTRL);
  assign access   = psel_i & penable_i;

  // Write lands on the access phase edge
  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      ctrl_q <= '0;
    end else if (access && pwrite_i && ctrl_hit) begin
      ctrl_q <= pwdata_i[CTRL_W-1:0];
    end
  end

  // Read data, unused bits and unmapped addresses give zero
  assign prdata_o  = (psel_i && ctrl_hit) ? {{(`DEC_APB_DW-CTRL_W){1'b0}}, ctrl_q} : '0;
  assign pready_o  = 1'b1;
  assign pslverr_o = access & ~ctrl_hit;

  // Field fan-out
  assign mode_o        = dec_mode_e'(ctrl_q[B_MODE+1:B_MODE]);
  assign sign_mag_o    = ctrl_q[B_SIGN_MAG];
  assign biphase_o     = ctrl_q[B_BIPHASE];
  assign swap_o        = ctrl_q[B_SWAP];
  assign demux_o       = ctrl_q[B_DEMUX];
  assign derandomize_o = ctrl_q[B_DERAND];
  assign data_inv_o    = ctrl_q[B_DATA_INV];
  assign clk_inv_o     = ctrl_q[B_CLK_INV];

endmodule

`default_nettype wire

// ==== src/decoder_pkg.sv ====
// Bit decoder shared types
// Soft-symbol layout and differential decode modes used
// across the decoder datapath and the control register

`default_nettype none

package decoder_pkg;

  `include "decoder_config.svh"

  // ----------------------------------------
  // Soft symbol layout
  // ----------------------------------------

  // Index of the hard decision bit
  localparam int unsigned SOFT_MSB = `DEC_SOFT_W - 1;

  // Full soft symbol, top bit is the hard decision (1 = one)
  typedef logic [`DEC_SOFT_W-1:0] soft_sym_t;

  // Confidence part only, offset binary
  typedef logic [`DEC_SOFT_W-2:0] soft_conf_t;

  // ----------------------------------------
  // Differential decode mode
  // ----------------------------------------

  // Value 3 is not named and decodes as NRZ-L
  typedef enum logic [1:0] {
    NRZ_L = 2'd0,
    // Transition means one
    NRZ_M = 2'd1,
    // No transition means one
    NRZ_S = 2'd2
  } dec_mode_e;

endpackage

`default_nettype wire

// ==== src/decoder_config.svh ====
// Bit decoder configuration
// Soft-symbol width, APB geometry and register map

`ifndef DECODER_CONFIG_SVH
`define DECODER_CONFIG_SVH

// ----------------------------------------
// Soft symbol
// ----------------------------------------

// Hard decision bit plus offset binary confidence
`define DEC_SOFT_W 3

// ----------------------------------------
// APB slave
// ----------------------------------------

`define DEC_APB_AW 12
`define DEC_APB_DW 16

// Register map, byte addresses
`define DEC_ADDR_CTRL 12'h000

`endif
